// File: all.f
rvPkg.sv
trapPkg.sv
alu.sv
branchUnit.sv
mulUnit.sv
dataMem.sv
trapUnit.sv
exeStage.sv
exeStage_sva.sv
tbExeStage.sv

// File: tbExeStage.sv
`timescale 1ns/1ns
`default_nettype none

module tbExeStage;
	import rvPkg::*;
	import trapPkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 2;
	localparam int TEST_CYCLES = 2000;
	localparam int BYTES = DMEM_WORDS * 4;

	// expected contents of one pipeline stage
	typedef struct packed {
		logic we;
		regAddr_t rd;
		word_t data;
		word_t pc;
		logic instrMis;
		logic ecall;
		logic illegal;
		logic mret;
		logic addrMis;
	} entry_t;

	logic clk = 1'b0;
	logic nrst;
	word_t opA;
	word_t opB;
	regAddr_t rd4;
	logic we4;
	wbSel_t wbSel4;
	aluFn_t aluFn4;
	logic isBranch4;
	brFn_t brFn4;
	logic jal4;
	logic jalr4;
	word_t bImm4;
	word_t jImm4;
	word_t uImm4;
	word_t sImm4;
	memOp_t memOp4;
	mulOp_t mulOp4;
	word_t pc4;
	logic instrMisaligned4;
	logic ecall4;
	logic illegal4;
	logic mret4;
	mode_t mode;
	logic mTimer;
	logic sTimer;
	logic mExt;
	logic sExt;
	logic mTie;
	logic sTie;
	logic mEie;
	logic sEie;
	word_t wbData;
	logic we6;
	regAddr_t rd6;
	logic bjTaken;
	word_t target;
	logic trap;
	cause_t cause;
	word_t pc6;
	logic mret6;

	word_t rngState = 32'd97;
	logic [7:0] mirror [BYTES];
	// index 0 is stage 6, index 1 is stage 5
	entry_t expQ [$];

	always #(CLK_PERIOD / 2) clk = ~clk;

	exeStage u_dut (
		.clk              (clk),
		.nrst             (nrst),
		.opA              (opA),
		.opB              (opB),
		.rd4              (rd4),
		.we4              (we4),
		.wbSel4           (wbSel4),
		.aluFn4           (aluFn4),
		.isBranch4        (isBranch4),
		.brFn4            (brFn4),
		.jal4             (jal4),
		.jalr4            (jalr4),
		.bImm4            (bImm4),
		.jImm4            (jImm4),
		.uImm4            (uImm4),
		.sImm4            (sImm4),
		.memOp4           (memOp4),
		.mulOp4           (mulOp4),
		.pc4              (pc4),
		.instrMisaligned4 (instrMisaligned4),
		.ecall4           (ecall4),
		.illegal4         (illegal4),
		.mret4            (mret4),
		.mode             (mode),
		.mTimer           (mTimer),
		.sTimer           (sTimer),
		.mExt             (mExt),
		.sExt             (sExt),
		.mTie             (mTie),
		.sTie             (sTie),
		.mEie             (mEie),
		.sEie             (sEie),
		.wbData           (wbData),
		.we6              (we6),
		.rd6              (rd6),
		.bjTaken          (bjTaken),
		.target           (target),
		.trap             (trap),
		.cause            (cause),
		.pc6              (pc6),
		.mret6            (mret6)
	);

	bind exeStage exeStage_sva uSva (
		.clk    (clk),
		.nrst   (nrst),
		.trap   (trap),
		.we6    (we6),
		.mTimer (mTimer),
		.sTimer (sTimer),
		.mExt   (mExt),
		.sExt   (sExt)
	);

	// xorshift32
	function automatic word_t nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic word_t aluModel(input aluFn_t fn, input word_t a, input word_t b);
		word_t fill;
		fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;
		case (fn)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_SLL: return a << b[4:0];
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return (a >> b[4:0]) | fill;
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			default: return 32'h0;
		endcase
	endfunction

	// 64-bit product of the extended operands, exact modulo 2^64
	function automatic word_t mulModel(input mulOp_t op, input word_t a, input word_t b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = (op == MUL_MULH || op == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'h0, a};
		eb = (op == MUL_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
		p = ea * eb;
		return (op == MUL_MUL) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic branchCmp(input brFn_t fn, input word_t a, input word_t b);
		case (fn)
			BR_BEQ: return a == b;
			BR_BNE: return a != b;
			BR_BLT: return $signed(a) < $signed(b);
			BR_BGE: return !($signed(a) < $signed(b));
			BR_BLTU: return a < b;
			BR_BGEU: return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic isStoreOp(input memOp_t op);
		return op == MEM_SB || op == MEM_SH || op == MEM_SW;
	endfunction

	function automatic logic isLoadOp(input memOp_t op);
		return op == MEM_LB || op == MEM_LH || op == MEM_LW || op == MEM_LBU || op == MEM_LHU;
	endfunction

	function automatic logic isMisaligned(input memOp_t op, input word_t addr);
		case (op)
			MEM_LH, MEM_LHU, MEM_SH: return addr[0];
			MEM_LW, MEM_SW: return addr[1:0] != 2'b00;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t loadModel(input memOp_t op, input word_t addr);
		int bi;
		logic [15:0] half;
		bi = int'(addr[DMEM_AW+1:0]);
		half = {mirror[bi+1], mirror[bi]};
		case (op)
			MEM_LB: return {{24{mirror[bi][7]}}, mirror[bi]};
			MEM_LBU: return {24'h0, mirror[bi]};
			MEM_LH: return {{16{half[15]}}, half};
			MEM_LHU: return {16'h0, half};
			MEM_LW: return {mirror[bi+3], mirror[bi+2], half};
			default: return 32'h0;
		endcase
	endfunction

	task automatic storeModel(input memOp_t op, input word_t addr, input word_t data);
		int bi;
		bi = int'(addr[DMEM_AW+1:0]);
		mirror[bi] = data[7:0];
		if (op == MEM_SH || op == MEM_SW)
			mirror[bi+1] = data[15:8];
		if (op == MEM_SW)
		begin
			mirror[bi+2] = data[23:16];
			mirror[bi+3] = data[31:24];
		end
	endtask

	// expected stage-6 contents of the instruction now at issue
	function automatic entry_t issueEntry();
		entry_t e;
		word_t addr;
		addr = isStoreOp(memOp4) ? opA + sImm4 : opA + opB;
		e = '0;
		e.we = we4;
		e.rd = rd4;
		e.pc = pc4;
		e.instrMis = instrMisaligned4;
		e.ecall = ecall4;
		e.illegal = illegal4;
		e.mret = mret4;
		e.addrMis = isMisaligned(memOp4, addr);
		case (wbSel4)
			WB_ALU: e.data = aluModel(aluFn4, opA, opB);
			WB_LINK: e.data = pc4 + 32'd4;
			WB_MUL: e.data = mulModel(mulOp4, opA, opB);
			WB_LUI: e.data = uImm4;
			WB_LOAD: e.data = (isLoadOp(memOp4) && !e.addrMis) ? loadModel(memOp4, addr) : '0;
			WB_AUIPC: e.data = uImm4 + pc4;
			default: e.data = '0;
		endcase
		return e;
	endfunction

	task automatic evalTrap(input entry_t s6, output logic t, output cause_t c);
		logic sOk;
		logic mE;
		logic sE;
		logic mT;
		logic sT;
		sOk = (mode != M);
		mE = mEie && mExt;
		sE = sOk && sEie && sExt;
		mT = mTie && mTimer;
		sT = sOk && sTie && sTimer;
		t = mE || sE || mT || sT || s6.instrMis || s6.ecall || s6.illegal || s6.addrMis
			|| s6.mret;
		if (mE)
			c = 32'h8000_0000 | M_INT_EXT;
		else if (sE)
			c = 32'h8000_0000 | S_INT_EXT;
		else if (mT)
			c = 32'h8000_0000 | M_INT_TIMER;
		else if (sT)
			c = 32'h8000_0000 | S_INT_TIMER;
		else if (s6.instrMis)
			c = I_ADDR_MISALIGNED;
		else if (s6.ecall)
			c = U_CALL + {30'h0, mode};
		else if (s6.illegal)
			c = I_ILLEGAL;
		else if (s6.addrMis)
			c = L_ADDR_MISALIGNED;
		else
			c = '0;
	endtask

	// model of one clock edge, called before new inputs are driven
	task automatic advanceModel();
		entry_t incoming;
		entry_t kept;
		logic t;
		cause_t c;
		evalTrap(expQ[0], t, c);
		incoming = issueEntry();
		if (t)
		begin
			kept = '0;
			kept.pc = expQ[0].pc;
			expQ[0] = kept;
			expQ[1] = '0;
		end
		else
		begin
			expQ[0] = expQ[1];
			expQ[1] = incoming;
			if (isStoreOp(memOp4) && !incoming.addrMis)
				storeModel(memOp4, opA + sImm4, opB);
		end
	endtask

	task automatic driveRandom();
		word_t r;
		word_t a;
		word_t b;
		word_t si;
		word_t addr;
		memOp_t op;
		r = nextRand() % 9;
		op = memOp_t'(r[3:0]);
		a = nextRand();
		b = nextRand();
		si = (nextRand() % 64) - 32;
		if (op != MEM_NONE)
		begin
			// low 32 words only, so loads often hit earlier stores
			addr = (nextRand() % 32) * 4;
			if (op == MEM_LB || op == MEM_LBU || op == MEM_SB)
				addr = addr + nextRand() % 4;
			else if (nextRand() % 8 == 0)
				addr = addr + 1 + (nextRand() % 2) * 2;
			else if (op == MEM_LH || op == MEM_LHU || op == MEM_SH)
				addr = addr + (nextRand() % 2) * 2;
			if (isStoreOp(op))
				a = addr - si;
			else
			begin
				b = si;
				a = addr - b;
			end
		end
		else if (nextRand() % 8 == 0)
			b = a;
		opA <= a;
		opB <= b;
		sImm4 <= si;
		memOp4 <= op;
		r = nextRand();
		rd4 <= r[4:0];
		we4 <= (nextRand() % 4) != 0;
		r = nextRand() % 6;
		wbSel4 <= wbSel_t'(r[2:0]);
		r = nextRand() % 10;
		aluFn4 <= aluFn_t'(r[3:0]);
		r = nextRand() % 4;
		mulOp4 <= mulOp_t'(r[1:0]);
		// branch funct3 codes skip 2 and 3
		r = nextRand() % 6;
		brFn4 <= brFn_t'((r < 2) ? r[2:0] : r[2:0] + 3'd2);
		r = nextRand() % 4;
		isBranch4 <= r == 1;
		jal4 <= r == 2;
		jalr4 <= r == 3;
		r = nextRand();
		bImm4 <= {{19{r[12]}}, r[12:1], 1'b0};
		r = nextRand();
		jImm4 <= {{11{r[20]}}, r[20:1], 1'b0};
		r = nextRand();
		uImm4 <= {r[31:12], 12'h000};
		r = nextRand();
		pc4 <= {r[31:2], 2'b00};
		instrMisaligned4 <= (nextRand() % 48) == 0;
		ecall4 <= (nextRand() % 48) == 0;
		illegal4 <= (nextRand() % 48) == 0;
		mret4 <= (nextRand() % 48) == 0;
		r = nextRand() % 3;
		mode <= (r == 0) ? U : ((r == 1) ? S : M);
		mTimer <= (nextRand() % 24) == 0;
		sTimer <= (nextRand() % 24) == 0;
		mExt <= (nextRand() % 24) == 0;
		sExt <= (nextRand() % 24) == 0;
		r = nextRand();
		mTie <= r[0];
		sTie <= r[1];
		mEie <= r[2];
		sEie <= r[3];
	endtask

	task automatic checkValue(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkAssertions();
		if (u_dut.uSva.failCount != 0)
		begin
			$display("A bound assertion failed before %0t ns", $time);
			$display("Checks failed");
			$fatal(1, "stopping after an assertion failure");
		end
	endtask

	// sampled mid-cycle, away from the driving edge
	task automatic checkOutputs();
		logic t;
		cause_t c;
		logic expTaken;
		word_t expTarget;
		evalTrap(expQ[0], t, c);
		checkValue(trap, t, "trap");
		checkValue(cause, c, "cause");
		checkValue(we6, expQ[0].we, "we6");
		checkValue(rd6, expQ[0].rd, "rd6");
		checkValue(wbData, expQ[0].data, "wbData");
		checkValue(pc6, expQ[0].pc, "pc6");
		checkValue(mret6, expQ[0].mret, "mret6");
		expTaken = jal4 || jalr4 || (isBranch4 && branchCmp(brFn4, opA, opB));
		checkValue(bjTaken, expTaken, "bjTaken");
		if (jalr4)
			expTarget = (opA + opB) & ~32'd1;
		else if (jal4)
			expTarget = pc4 + jImm4;
		else
			expTarget = pc4 + bImm4;
		if (isBranch4 || jal4 || jalr4)
			checkValue(target, expTarget, "target");
	endtask

	initial
	begin
		nrst = 1'b0;
		opA = '0;
		opB = '0;
		rd4 = '0;
		we4 = 1'b0;
		wbSel4 = WB_ALU;
		aluFn4 = ALU_ADD;
		isBranch4 = 1'b0;
		brFn4 = BR_BEQ;
		jal4 = 1'b0;
		jalr4 = 1'b0;
		bImm4 = '0;
		jImm4 = '0;
		uImm4 = '0;
		sImm4 = '0;
		memOp4 = MEM_NONE;
		mulOp4 = MUL_MUL;
		pc4 = '0;
		instrMisaligned4 = 1'b0;
		ecall4 = 1'b0;
		illegal4 = 1'b0;
		mret4 = 1'b0;
		mode = M;
		mTimer = 1'b0;
		sTimer = 1'b0;
		mExt = 1'b0;
		sExt = 1'b0;
		mTie = 1'b0;
		sTie = 1'b0;
		mEie = 1'b0;
		sEie = 1'b0;
		for (int i = 0; i < BYTES; i++)
			mirror[i] = 8'h00;
		expQ.push_back('0);
		expQ.push_back('0);
		repeat (RESET_CYCLES) @(posedge clk);
		nrst <= 1'b1;
		for (int n = 0; n < TEST_CYCLES; n++)
		begin
			@(posedge clk);
			advanceModel();
			driveRandom();
			@(negedge clk);
			checkOutputs();
			checkAssertions();
		end
		$display("All checks passed");
		$finish;
	end

	initial
	begin
		#((RESET_CYCLES + TEST_CYCLES + 10) * CLK_PERIOD);
		$display("Checks failed");
		$fatal(1, "watchdog expired before the test sequence finished");
	end

endmodule

`default_nettype wire

// File: exeStage_sva.sv
`timescale 1ns/1ns
`default_nettype none

module exeStage_sva (
	input logic clk,
	input logic nrst,
	input logic trap,
	input logic we6,
	input logic mTimer,
	input logic sTimer,
	input logic mExt,
	input logic sExt
);

	logic intPending;
	int failCount = 0;

	assign intPending = mTimer || sTimer || mExt || sExt;

	// the edge after a trap empties stage 6
	flushClearsWe: assert property (@(posedge clk) disable iff (!nrst) trap |=> !we6)
		else
		begin
			$error("we6 high in the cycle after a trap");
			failCount++;
		end

	resetQuiet: assert property (@(posedge clk) $rose(nrst) |-> (!we6 && !trap))
		else
		begin
			$error("we6 or trap high right after reset release");
			failCount++;
		end

	// flushed entries hold no exception flags
	flushNoRetrap: assert property (@(posedge clk) disable iff (!nrst)
		trap |=> (!trap || intPending))
		else
		begin
			$error("trap repeated from a flushed stage 6 without a pending interrupt");
			failCount++;
		end

endmodule

`default_nettype wire

// File: exeStage.sv
`timescale 1ns/1ns
`default_nettype none

module exeStage (
	input  logic             clk,
	input  logic             nrst,
	input  rvPkg::word_t     opA,
	input  rvPkg::word_t     opB,
	input  rvPkg::regAddr_t  rd4,
	input  logic             we4,
	input  rvPkg::wbSel_t    wbSel4,
	input  rvPkg::aluFn_t    aluFn4,
	input  logic             isBranch4,
	input  rvPkg::brFn_t     brFn4,
	input  logic             jal4,
	input  logic             jalr4,
	input  rvPkg::word_t     bImm4,
	input  rvPkg::word_t     jImm4,
	input  rvPkg::word_t     uImm4,
	input  rvPkg::word_t     sImm4,
	input  rvPkg::memOp_t    memOp4,
	input  rvPkg::mulOp_t    mulOp4,
	input  rvPkg::word_t     pc4,
	input  logic             instrMisaligned4,
	input  logic             ecall4,
	input  logic             illegal4,
	input  logic             mret4,
	input  trapPkg::mode_t   mode,
	input  logic             mTimer,
	input  logic             sTimer,
	input  logic             mExt,
	input  logic             sExt,
	input  logic             mTie,
	input  logic             sTie,
	input  logic             mEie,
	input  logic             sEie,
	output rvPkg::word_t     wbData,
	output logic             we6,
	output rvPkg::regAddr_t  rd6,
	output logic             bjTaken,
	output rvPkg::word_t     target,
	output logic             trap,
	output trapPkg::cause_t  cause,
	output rvPkg::word_t     pc6,
	output logic             mret6
);
	import rvPkg::*;

	// stage 5
	word_t opA5;
	word_t opB5;
	word_t uImm5;
	word_t pc5;
	regAddr_t rd5;
	logic we5;
	wbSel_t wbSel5;
	aluFn_t aluFn5;
	mulOp_t mulOp5;
	logic instrMis5;
	logic ecall5;
	logic illegal5;
	logic mret5;
	word_t aluRes5;
	word_t mulRes5;

	// stage 6
	word_t aluRes6;
	word_t mulRes6;
	word_t uImm6;
	word_t auipc6;
	word_t loadData6;
	wbSel_t wbSel6;
	logic instrMis6;
	logic ecall6;
	logic illegal6;
	logic addrMis6;

	// a trap squashes whatever enters stage 5
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5 <= '0;
			opB5 <= '0;
			uImm5 <= '0;
			pc5 <= '0;
			rd5 <= '0;
			we5 <= 1'b0;
			wbSel5 <= WB_ALU;
			aluFn5 <= ALU_ADD;
			mulOp5 <= MUL_MUL;
			instrMis5 <= 1'b0;
			ecall5 <= 1'b0;
			illegal5 <= 1'b0;
			mret5 <= 1'b0;
		end
		else
		begin
			opA5 <= trap ? '0 : opA;
			opB5 <= trap ? '0 : opB;
			uImm5 <= trap ? '0 : uImm4;
			pc5 <= trap ? '0 : pc4;
			rd5 <= trap ? '0 : rd4;
			we5 <= !trap && we4;
			wbSel5 <= trap ? WB_ALU : wbSel4;
			aluFn5 <= trap ? ALU_ADD : aluFn4;
			mulOp5 <= trap ? MUL_MUL : mulOp4;
			instrMis5 <= !trap && instrMisaligned4;
			ecall5 <= !trap && ecall4;
			illegal5 <= !trap && illegal4;
			mret5 <= !trap && mret4;
		end
	end

	// pc6 holds the trapping pc while trap is up
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6 <= '0;
			mulRes6 <= '0;
			uImm6 <= '0;
			auipc6 <= '0;
			pc6 <= '0;
			rd6 <= '0;
			we6 <= 1'b0;
			wbSel6 <= WB_ALU;
			instrMis6 <= 1'b0;
			ecall6 <= 1'b0;
			illegal6 <= 1'b0;
			mret6 <= 1'b0;
		end
		else
		begin
			aluRes6 <= trap ? '0 : aluRes5;
			mulRes6 <= trap ? '0 : mulRes5;
			uImm6 <= trap ? '0 : uImm5;
			auipc6 <= trap ? '0 : uImm5 + pc5;
			pc6 <= trap ? pc6 : pc5;
			rd6 <= trap ? '0 : rd5;
			we6 <= !trap && we5;
			wbSel6 <= trap ? WB_ALU : wbSel5;
			instrMis6 <= !trap && instrMis5;
			ecall6 <= !trap && ecall5;
			illegal6 <= !trap && illegal5;
			mret6 <= !trap && mret5;
		end
	end

	always_comb
	begin
		case (wbSel6)
			WB_ALU:
				wbData = aluRes6;
			WB_LINK:
				wbData = pc6 + word_t'(4);
			WB_MUL:
				wbData = mulRes6;
			WB_LUI:
				wbData = uImm6;
			WB_LOAD:
				wbData = loadData6;
			WB_AUIPC:
				wbData = auipc6;
			default:
				wbData = '0;
		endcase
	end

	alu uAlu (
		.aluFn  (aluFn5),
		.a      (opA5),
		.b      (opB5),
		.result (aluRes5)
	);

	mulUnit uMul (
		.op     (mulOp5),
		.a      (opA5),
		.b      (opB5),
		.result (mulRes5)
	);

	// resolved in the issue cycle
	branchUnit uBranch (
		.pc       (pc4),
		.opA      (opA),
		.opB      (opB),
		.bImm     (bImm4),
		.jImm     (jImm4),
		.isBranch (isBranch4),
		.brFn     (brFn4),
		.jal      (jal4),
		.jalr     (jalr4),
		.taken    (bjTaken),
		.target   (target)
	);

	dataMem uDmem (
		.clk         (clk),
		.nrst        (nrst),
		.memOp       (memOp4),
		.base        (opA),
		.opB         (opB),
		.sImm        (sImm4),
		.kill        (trap),
		.loadData6   (loadData6),
		.misaligned6 (addrMis6)
	);

	trapUnit uTrap (
		.mode      (mode),
		.instrMis6 (instrMis6),
		.ecall6    (ecall6),
		.illegal6  (illegal6),
		.mret6     (mret6),
		.addrMis6  (addrMis6),
		.mTimer    (mTimer),
		.sTimer    (sTimer),
		.mExt      (mExt),
		.sExt      (sExt),
		.mTie      (mTie),
		.sTie      (sTie),
		.mEie      (mEie),
		.sEie      (sEie),
		.trap      (trap),
		.cause     (cause)
	);

endmodule

`default_nettype wire

// File: trapUnit.sv
`timescale 1ns/1ns
`default_nettype none

module trapUnit (
	input  trapPkg::mode_t  mode,
	input  logic            instrMis6,
	input  logic            ecall6,
	input  logic            illegal6,
	input  logic            mret6,
	input  logic            addrMis6,
	input  logic            mTimer,
	input  logic            sTimer,
	input  logic            mExt,
	input  logic            sExt,
	input  logic            mTie,
	input  logic            sTie,
	input  logic            mEie,
	input  logic            sEie,
	output logic            trap,
	output trapPkg::cause_t cause
);
	import trapPkg::*;

	logic sAllowed;
	logic mTimerOn;
	logic sTimerOn;
	logic mExtOn;
	logic sExtOn;
	logic anyInt;

	// supervisor interrupts are masked while running in M mode
	assign sAllowed = (mode <= S);
	assign mTimerOn = mTie && mTimer;
	assign sTimerOn = sAllowed && sTie && sTimer;
	assign mExtOn = mEie && mExt;
	assign sExtOn = sAllowed && sEie && sExt;
	assign anyInt = mExtOn || sExtOn || mTimerOn || sTimerOn;

	assign trap = anyInt || instrMis6 || ecall6 || illegal6 || addrMis6 || mret6;

	always_comb
	begin
		cause = '0;
		if (mExtOn)
			cause = M_INT_EXT;
		else if (sExtOn)
			cause = S_INT_EXT;
		else if (mTimerOn)
			cause = M_INT_TIMER;
		else if (sTimerOn)
			cause = S_INT_TIMER;
		else if (instrMis6)
			cause = I_ADDR_MISALIGNED;
		else if (ecall6)
			cause = U_CALL + cause_t'(mode);
		else if (illegal6)
			cause = I_ILLEGAL;
		else if (addrMis6)
			cause = L_ADDR_MISALIGNED;
		cause[INT_BIT] = anyInt;
	end

endmodule

`default_nettype wire

// File: dataMem.sv
`timescale 1ns/1ns
`default_nettype none

module dataMem (
	input  logic           clk,
	input  logic           nrst,
	input  rvPkg::memOp_t  memOp,
	input  rvPkg::word_t   base,
	input  rvPkg::word_t   opB,
	input  rvPkg::word_t   sImm,
	input  logic           kill,
	output rvPkg::word_t   loadData6,
	output logic           misaligned6
);
	import rvPkg::*;

	word_t mem [DMEM_WORDS];
	word_t addr;
	word_t rdWord;
	word_t shifted;
	word_t ldData;
	word_t ldData5;
	logic [DMEM_AW-1:0] idx;
	logic isLoad;
	logic isStore;
	logic isHalf;
	logic isWord;
	logic mis;
	logic mis5;

	assign isStore = memOp inside {MEM_SB, MEM_SH, MEM_SW};
	assign isLoad = memOp inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	assign isHalf = memOp inside {MEM_LH, MEM_LHU, MEM_SH};
	assign isWord = memOp inside {MEM_LW, MEM_SW};

	// stores offset by sImm, loads by the I-immediate in opB
	assign addr = isStore ? base + sImm : base + opB;
	assign idx = addr[DMEM_AW+1:2];
	assign mis = (isHalf && addr[0]) || (isWord && addr[1:0] != 2'b00);

	assign rdWord = mem[idx];
	assign shifted = rdWord >> {addr[1:0], 3'b000};

	always_comb
	begin
		ldData = '0;
		if (isLoad && !mis)
		begin
			case (memOp)
				MEM_LB:
					ldData = {{24{shifted[7]}}, shifted[7:0]};
				MEM_LBU:
					ldData = {24'b0, shifted[7:0]};
				MEM_LH:
					ldData = {{16{shifted[15]}}, shifted[15:0]};
				MEM_LHU:
					ldData = {16'b0, shifted[15:0]};
				MEM_LW:
					ldData = rdWord;
				default:
					ldData = '0;
			endcase
		end
	end

	// byte-lane writes at the issue edge
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (isStore && !mis && !kill)
		begin
			case (memOp)
				MEM_SB:
					mem[idx][{addr[1:0], 3'b000} +: 8] <= opB[7:0];
				MEM_SH:
					mem[idx][{addr[1], 4'b0000} +: 16] <= opB[15:0];
				default:
					mem[idx] <= opB;
			endcase
		end
	end

	// two register stages to line up with stage 6
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ldData5 <= '0;
			mis5 <= 1'b0;
			loadData6 <= '0;
			misaligned6 <= 1'b0;
		end
		else
		begin
			ldData5 <= kill ? '0 : ldData;
			mis5 <= !kill && mis;
			loadData6 <= kill ? '0 : ldData5;
			misaligned6 <= !kill && mis5;
		end
	end

endmodule

`default_nettype wire

// File: mulUnit.sv
`timescale 1ns/1ns
`default_nettype none

module mulUnit (
	input  rvPkg::mulOp_t op,
	input  rvPkg::word_t  a,
	input  rvPkg::word_t  b,
	output rvPkg::word_t  result
);
	import rvPkg::*;

	logic signed [32:0] aExt;
	logic signed [32:0] bExt;
	logic signed [65:0] prod;
	logic aSigned;
	logic bSigned;

	// mulhsu treats only rs1 as signed
	assign aSigned = (op == MUL_MULH) || (op == MUL_MULHSU);
	assign bSigned = (op == MUL_MULH);

	always_comb
	begin
		aExt = {aSigned && a[31], a};
		bExt = {bSigned && b[31], b};
		prod = aExt * bExt;
	end

	// low word for mul, upper word for the mulh variants
	assign result = (op == MUL_MUL) ? prod[31:0] : prod[63:32];

endmodule

`default_nettype wire

// File: branchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module branchUnit (
	input  rvPkg::word_t  pc,
	input  rvPkg::word_t  opA,
	input  rvPkg::word_t  opB,
	input  rvPkg::word_t  bImm,
	input  rvPkg::word_t  jImm,
	input  logic          isBranch,
	input  rvPkg::brFn_t  brFn,
	input  logic          jal,
	input  logic          jalr,
	output logic          taken,
	output rvPkg::word_t  target
);
	import rvPkg::*;

	logic cmp;

	always_comb
	begin
		case (brFn)
			BR_BEQ:
				cmp = opA == opB;
			BR_BNE:
				cmp = opA != opB;
			BR_BLT:
				cmp = $signed(opA) < $signed(opB);
			BR_BGE:
				cmp = $signed(opA) >= $signed(opB);
			BR_BLTU:
				cmp = opA < opB;
			BR_BGEU:
				cmp = opA >= opB;
			default:
				cmp = 1'b0;
		endcase
	end

	assign taken = (isBranch && cmp) || jal || jalr;

	always_comb
	begin
		if (jalr)
		begin
			// opB carries the I-immediate here
			target = opA + opB;
			target[0] = 1'b0;
		end
		else if (jal)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  rvPkg::aluFn_t aluFn,
	input  rvPkg::word_t  a,
	input  rvPkg::word_t  b,
	output rvPkg::word_t  result
);
	import rvPkg::*;

	logic [4:0] shamt;

	// only the low five bits count for RV32 shifts
	assign shamt = b[4:0];

	always_comb
	begin
		case (aluFn)
			ALU_ADD:
				result = a + b;
			ALU_SUB:
				result = a - b;
			ALU_SLL:
				result = a << shamt;
			ALU_SLT:
				result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:
				result = {31'b0, a < b};
			ALU_XOR:
				result = a ^ b;
			ALU_SRL:
				result = a >> shamt;
			ALU_SRA:
				result = word_t'($signed(a) >>> shamt);
			ALU_OR:
				result = a | b;
			ALU_AND:
				result = a & b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: trapPkg.sv
`default_nettype none

package trapPkg;

	typedef enum logic [1:0] {
		U = 2'd0,
		S = 2'd1,
		M = 2'd3
	} mode_t;

	typedef logic [31:0] cause_t;

	// synchronous exception codes
	localparam cause_t I_ADDR_MISALIGNED = 32'd0;
	localparam cause_t I_ILLEGAL = 32'd2;
	localparam cause_t L_ADDR_MISALIGNED = 32'd4;
	localparam cause_t U_CALL = 32'd8;

	// interrupt codes, flagged by INT_BIT
	localparam cause_t S_INT_TIMER = 32'd5;
	localparam cause_t M_INT_TIMER = 32'd7;
	localparam cause_t S_INT_EXT = 32'd9;
	localparam cause_t M_INT_EXT = 32'd11;
	localparam int INT_BIT = 31;

endpackage

`default_nettype wire

// File: rvPkg.sv
`default_nettype none

package rvPkg;

	localparam int XLEN = 32;

	// data memory geometry, in 32-bit words
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} aluFn_t;

	// funct3 encodings of the branch instructions
	typedef enum logic [2:0] {
		BR_BEQ = 3'd0,
		BR_BNE = 3'd1,
		BR_BLT = 3'd4,
		BR_BGE = 3'd5,
		BR_BLTU = 3'd6,
		BR_BGEU = 3'd7
	} brFn_t;

	typedef enum logic [1:0] {
		MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
	} mulOp_t;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
		MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} memOp_t;

	// write-back source select at stage 6
	typedef enum logic [2:0] {
		WB_ALU, WB_LINK, WB_MUL, WB_LUI, WB_LOAD, WB_AUIPC
	} wbSel_t;

endpackage

`default_nettype wire
